// File: verilog/lsuPkg.sv
`default_nettype none

package lsuPkg;

    // Byte address bits seen by the RAM.
    parameter int ADDR_W = 10;

    // Rename tag width.
    parameter int TAG_W = 4;

    // Data path width.
    parameter int DATA_W = 32;

    typedef enum logic [1:0] {
        lenByte = 2'd0,
        lenHalf = 2'd1,
        lenWord = 2'd2
    } memLen_t;

    // One memory operation from dispatch.
    typedef struct packed {
        logic                isStore;
        memLen_t             len;
        logic [31:0]         addr;
        logic [DATA_W-1:0]   data;     // Store data.
        logic [TAG_W-1:0]    tag;
    } memReq_t;

    // One completion back to the core.
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [DATA_W-1:0]   data;     // Zero for a store.
    } memResp_t;

    // Number of bytes moved for a length code.
    function automatic logic [2:0] lenBytes(input memLen_t len);
        logic [2:0] n;
        case (len)
            lenByte: n = 3'd1;
            lenHalf: n = 3'd2;
            default: n = 3'd4;
        endcase
        return n;
    endfunction

endpackage

`default_nettype wire

// File: verilog/loadStoreBuffer.sv
`timescale 1ns/1ns
`default_nettype none

module loadStoreBuffer #(
    parameter int DEPTH = 4
) (
    input  wire            clk,
    input  wire            rst,

    input  wire            issueValid,
    input  lsuPkg::memReq_t issue,
    output logic           issueCredit,

    output logic           portValid,
    output lsuPkg::memReq_t portReq,
    input  wire            portCredit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    lsuPkg::memReq_t entries [DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             portCreditCnt;   // One operation may be in flight.
    logic             send;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] n;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            n = '0;
        end else begin
            n = ptr + 1'b1;
        end
        return n;
    endfunction

    // Head leaves whenever there is something queued and a port credit.
    assign send      = (count != '0) && portCreditCnt;
    assign portValid = send;
    assign portReq   = entries[head];

    always_ff @(posedge clk) begin
        if (issueValid) begin
            entries[tail] <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (issueValid) begin
                tail <= nextPtr(tail);
            end
            if (send) begin
                head <= nextPtr(head);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count + CNT_W'(issueValid) - CNT_W'(send);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            portCreditCnt <= 1'b1;
        end else if (send && !portCredit) begin
            portCreditCnt <= 1'b0;
        end else if (portCredit && !send) begin
            portCreditCnt <= 1'b1;
        end
    end

    // Slot freed by the departing entry goes back to the issuer.
    always_ff @(posedge clk) begin
        if (rst) begin
            issueCredit <= 1'b0;
        end else begin
            issueCredit <= send;
        end
    end

endmodule

`default_nettype wire

// File: verilog/dataPort.sv
`timescale 1ns/1ns
`default_nettype none

module dataPort (
    input  wire                        clk,
    input  wire                        rst,

    input  wire                        portValid,
    input  lsuPkg::memReq_t            portReq,
    output logic                       portCredit,

    output logic                       mcStart,
    output lsuPkg::memReq_t            mcReq,
    input  wire                        mcDone,
    input  wire [lsuPkg::DATA_W-1:0]   mcData,

    output logic                       respValid,
    output lsuPkg::memResp_t           resp
);

    logic occupied;
    logic accept;
    logic finish;

    assign accept = portValid && !occupied;
    assign finish = mcDone && occupied;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied   <= 1'b0;
            mcStart    <= 1'b0;
            respValid  <= 1'b0;
            portCredit <= 1'b0;
        end else begin
            mcStart    <= accept;      // One-cycle start pulse.
            respValid  <= finish;
            portCredit <= finish;      // Slot is free again.
            if (finish) begin
                occupied <= 1'b0;
            end
            if (accept) begin
                occupied <= 1'b1;
            end
        end
    end

    // Held operation, tag included.
    always_ff @(posedge clk) begin
        if (accept) begin
            mcReq <= portReq;
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            resp.tag  <= mcReq.tag;
            resp.data <= mcData;
        end
    end

endmodule

`default_nettype wire

// File: verilog/memCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module memCtrl #(
    parameter int RAM_AW = 10
) (
    input  wire                        clk,
    input  wire                        rst,

    input  wire                        mcStart,
    input  lsuPkg::memReq_t            mcReq,
    output logic                       mcDone,
    output logic [lsuPkg::DATA_W-1:0]  mcData,

    output logic                       ramWe,
    output logic [RAM_AW-1:0]          ramAddr,
    output logic [7:0]                 ramWdata,
    input  wire  [7:0]                 ramRdata
);

    typedef enum logic [1:0] {
        stIdle,
        stActive,
        stFinish
    } state_t;

    state_t          state;
    lsuPkg::memReq_t held;
    logic [2:0]      numBytes;
    logic [2:0]      nextIdx;      // Next byte to put on the RAM port.
    logic            rdPending;    // A load byte returns this cycle.
    logic [1:0]      rdIdx;
    logic [lsuPkg::DATA_W-1:0] data;

    lsuPkg::memReq_t curReq;
    logic [2:0]      curIdx;
    logic            issueByte;
    logic            lastIssue;

    // Byte 0 goes out in the start cycle straight from the request.
    assign curReq    = (state == stIdle) ? mcReq : held;
    assign curIdx    = (state == stIdle) ? 3'd0 : nextIdx;
    assign issueByte = (state == stIdle && mcStart) ||
                       (state == stActive && nextIdx != numBytes);
    assign lastIssue = (state == stIdle) ? (lsuPkg::lenBytes(mcReq.len) == 3'd1)
                                         : (nextIdx + 3'd1 == numBytes);

    assign ramWe    = issueByte && curReq.isStore;
    assign ramAddr  = curReq.addr[RAM_AW-1:0] + RAM_AW'(curIdx);
    assign ramWdata = curReq.data[{curIdx[1:0], 3'b000} +: 8];

    assign mcDone = (state == stFinish);
    assign mcData = data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= stIdle;
            nextIdx   <= '0;
            rdPending <= 1'b0;
        end else begin
            rdPending <= issueByte && !curReq.isStore;
            if (issueByte) begin
                nextIdx <= curIdx + 3'd1;
            end
            case (state)
                stIdle: begin
                    if (mcStart) begin
                        state <= (mcReq.isStore && lastIssue) ? stFinish : stActive;
                    end
                end
                stActive: begin
                    if (held.isStore) begin
                        if (lastIssue) begin
                            state <= stFinish;
                        end
                    end else if (!issueByte && rdPending) begin
                        state <= stFinish;   // Last load byte lands now.
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && mcStart) begin
            held     <= mcReq;
            numBytes <= lsuPkg::lenBytes(mcReq.len);
        end
        rdIdx <= curIdx[1:0];
    end

    // Little-endian assembly, upper bytes stay zero.
    always_ff @(posedge clk) begin
        if (state == stIdle && mcStart) begin
            data <= '0;
        end else if (rdPending) begin
            data[{rdIdx, 3'b000} +: 8] <= ramRdata;
        end
    end

endmodule

`default_nettype wire

// File: verilog/dataRam.sv
`timescale 1ns/1ns
`default_nettype none

module dataRam #(
    parameter int RAM_AW = 10
) (
    input  wire                clk,
    input  wire                we,
    input  wire  [RAM_AW-1:0]  addr,
    input  wire  [7:0]         wdata,
    output logic [7:0]         rdata
);

    localparam int BYTES = 2 ** RAM_AW;

    logic [7:0] mem [BYTES];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Registered read, data one cycle after the address.
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: verilog/lsuTop.sv
`timescale 1ns/1ns
`default_nettype none

module lsuTop #(
    parameter int DEPTH  = 4,
    parameter int RAM_AW = lsuPkg::ADDR_W
) (
    input  wire              clk,
    input  wire              rst,

    input  wire              issueValid,
    input  lsuPkg::memReq_t  issue,
    output logic             issueCredit,

    output logic             respValid,
    output lsuPkg::memResp_t resp
);

    logic                      portValid;
    lsuPkg::memReq_t           portReq;
    logic                      portCredit;

    logic                      mcStart;
    lsuPkg::memReq_t           mcReq;
    logic                      mcDone;
    logic [lsuPkg::DATA_W-1:0] mcData;

    logic                      ramWe;
    logic [RAM_AW-1:0]         ramAddr;
    logic [7:0]                ramWdata;
    logic [7:0]                ramRdata;

    loadStoreBuffer #(
        .DEPTH(DEPTH)
    ) i_lsb (
        .clk        (clk),
        .rst        (rst),
        .issueValid (issueValid),
        .issue      (issue),
        .issueCredit(issueCredit),
        .portValid  (portValid),
        .portReq    (portReq),
        .portCredit (portCredit)
    );

    dataPort i_port (
        .clk       (clk),
        .rst       (rst),
        .portValid (portValid),
        .portReq   (portReq),
        .portCredit(portCredit),
        .mcStart   (mcStart),
        .mcReq     (mcReq),
        .mcDone    (mcDone),
        .mcData    (mcData),
        .respValid (respValid),
        .resp      (resp)
    );

    memCtrl #(
        .RAM_AW(RAM_AW)
    ) i_mc (
        .clk     (clk),
        .rst     (rst),
        .mcStart (mcStart),
        .mcReq   (mcReq),
        .mcDone  (mcDone),
        .mcData  (mcData),
        .ramWe   (ramWe),
        .ramAddr (ramAddr),
        .ramWdata(ramWdata),
        .ramRdata(ramRdata)
    );

    dataRam #(
        .RAM_AW(RAM_AW)
    ) i_ram (
        .clk  (clk),
        .we   (ramWe),
        .addr (ramAddr),
        .wdata(ramWdata),
        .rdata(ramRdata)
    );

endmodule

`default_nettype wire

// File: sim/lsuTb.sv
`timescale 1ns/1ns
`default_nettype none

module lsuTb;

    localparam int DEPTH    = 4;
    localparam int RAM_AW   = lsuPkg::ADDR_W;
    localparam int NUM_ROWS = 16;
    localparam int TIMEOUT  = 40 * NUM_ROWS + 100;

    typedef struct packed {
        logic              isStore;
        lsuPkg::memLen_t   len;
        logic [31:0]       addr;
        logic [31:0]       data;
        logic [31:0]       expData;    // Load result, zero for a store.
        logic              burst;      // Issued with no gap.
    } row_t;

    logic              clk;
    logic              rst;
    logic              issueValid;
    lsuPkg::memReq_t   issue;
    logic              issueCredit;
    logic              respValid;
    lsuPkg::memResp_t  resp;

    row_t              rows [NUM_ROWS];
    logic [7:0]        model [2 ** RAM_AW];
    lsuPkg::memResp_t  expQ [$];
    int                credits;
    int                valueErrors;
    int                otherErrors;
    int                cycles;
    int unsigned       seedDummy;

    lsuTop #(
        .DEPTH (DEPTH),
        .RAM_AW(RAM_AW)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .issueValid (issueValid),
        .issue      (issue),
        .issueCredit(issueCredit),
        .respValid  (respValid),
        .resp       (resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int byteCount(input lsuPkg::memLen_t len);
        int n;
        case (len)
            lsuPkg::lenByte: n = 1;
            lsuPkg::lenHalf: n = 2;
            default:         n = 4;
        endcase
        return n;
    endfunction

    task automatic fillTable;
        rows[0]  = '{1'b1, lsuPkg::lenWord, 32'h010, 32'hdeadbeef, 32'h0, 1'b0};
        rows[1]  = '{1'b0, lsuPkg::lenWord, 32'h010, 32'h0, 32'hdeadbeef, 1'b0};
        rows[2]  = '{1'b1, lsuPkg::lenByte, 32'h011, 32'h1234565a, 32'h0, 1'b0};
        rows[3]  = '{1'b1, lsuPkg::lenHalf, 32'h012, 32'habcd9876, 32'h0, 1'b0};
        rows[4]  = '{1'b0, lsuPkg::lenWord, 32'h010, 32'h0, 32'h98765aef, 1'b0};
        rows[5]  = '{1'b0, lsuPkg::lenByte, 32'h013, 32'h0, 32'h00000098, 1'b0};
        rows[6]  = '{1'b0, lsuPkg::lenHalf, 32'h011, 32'h0, 32'h0000765a, 1'b0};
        rows[7]  = '{1'b1, lsuPkg::lenWord, 32'h020, 32'h11223344, 32'h0, 1'b1};
        rows[8]  = '{1'b1, lsuPkg::lenWord, 32'h024, 32'h55667788, 32'h0, 1'b1};
        rows[9]  = '{1'b0, lsuPkg::lenWord, 32'h020, 32'h0, 32'h11223344, 1'b1};
        rows[10] = '{1'b0, lsuPkg::lenHalf, 32'h026, 32'h0, 32'h00005566, 1'b1};
        rows[11] = '{1'b1, lsuPkg::lenByte, 32'h3ff, 32'h000000a5, 32'h0, 1'b0};
        rows[12] = '{1'b0, lsuPkg::lenByte, 32'h3ff, 32'h0, 32'h000000a5, 1'b0};
        rows[13] = '{1'b0, lsuPkg::lenWord, 32'h024, 32'h0, 32'h55667788, 1'b0};
        rows[14] = '{1'b1, lsuPkg::lenHalf, 32'h021, 32'h0000beef, 32'h0, 1'b0};
        rows[15] = '{1'b0, lsuPkg::lenWord, 32'h020, 32'h0, 32'h11beef44, 1'b0};
    endtask

    // Credit returns and in-order completions.
    task automatic watchOutputs;
        lsuPkg::memResp_t exp;
        if (issueCredit) begin
            credits++;
            assert (credits <= DEPTH) else begin
                otherErrors++;
                $display("Issue credit returned beyond the %0d held after reset", DEPTH);
            end
        end
        if (respValid) begin
            assert (expQ.size() > 0) else begin
                otherErrors++;
                $display("Response with tag %h arrived while nothing was outstanding",
                         resp.tag);
            end
            if (expQ.size() > 0) begin
                exp = expQ.pop_front();
                assert (resp.tag == exp.tag) else begin
                    valueErrors++;
                    $display("** Error: resp.tag = %h, expected %h", resp.tag, exp.tag);
                end
                assert (resp.data == exp.data) else begin
                    valueErrors++;
                    $display("** Error: resp.data = %h, expected %h (tag %h)",
                             resp.data, exp.data, exp.tag);
                end
            end
        end
    endtask

    task automatic nextCycle;
        @(negedge clk);
        issueValid = 1'b0;
        watchOutputs();
    endtask

    task automatic waitBeforeRow(input int idx);
        int gap;
        if (rows[idx].burst) begin
            // A burst starts with every credit back home.
            if (idx == 0 || !rows[idx - 1].burst) begin
                while (credits != DEPTH) begin
                    nextCycle();
                end
            end
        end else begin
            gap = $urandom_range(0, 3);
            repeat (gap) begin
                nextCycle();
            end
        end
        nextCycle();
        while (credits == 0) begin
            nextCycle();
        end
    endtask

    // Drives one row and updates the byte model at issue time.
    task automatic applyRow(input int idx);
        row_t              r;
        int                k;
        logic [RAM_AW-1:0] a;
        logic [31:0]       value;
        lsuPkg::memResp_t  e;
        r = rows[idx];
        issueValid    = 1'b1;
        issue.isStore = r.isStore;
        issue.len     = r.len;
        issue.addr    = r.addr;
        issue.data    = r.data;
        issue.tag     = lsuPkg::TAG_W'(idx);
        credits--;
        value = '0;
        for (k = 0; k < byteCount(r.len); k++) begin
            a = r.addr[RAM_AW-1:0] + RAM_AW'(k);
            if (r.isStore) begin
                model[a] = r.data[8*k +: 8];
            end else begin
                value[8*k +: 8] = model[a];
            end
        end
        assert (value == r.expData) else begin
            valueErrors++;
            $display("** Error: model data = %h, table expects %h (row %0d)",
                     value, r.expData, idx);
        end
        e.tag  = lsuPkg::TAG_W'(idx);
        e.data = value;
        expQ.push_back(e);
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d responses outstanding",
                 cycles, expQ.size());
        $display("Errors: %0d value, %0d other", valueErrors, otherErrors);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        issueValid  = 1'b0;
        issue       = '0;
        credits     = DEPTH;
        valueErrors = 0;
        otherErrors = 0;
        seedDummy   = $urandom(32'hdbae);
        fillTable();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Quiet outputs with nothing issued.
        repeat (8) begin
            nextCycle();
            assert (!respValid && !issueCredit) else begin
                otherErrors++;
                $display("Response or issue credit seen before anything was issued");
            end
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            waitBeforeRow(i);
            applyRow(i);
        end

        while (expQ.size() > 0) begin
            nextCycle();
        end
        repeat (4) nextCycle();
        assert (credits == DEPTH) else begin
            otherErrors++;
            $display("Issuer ended with %0d credits instead of %0d", credits, DEPTH);
        end

        $display("Errors: %0d value, %0d other", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
verilog/lsuPkg.sv
verilog/loadStoreBuffer.sv
verilog/dataPort.sv
verilog/memCtrl.sv
verilog/dataRam.sv
verilog/lsuTop.sv
sim/lsuTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= lsuTb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJDIR)
